// File: hw/hazardPkg.sv
`default_nettype none

package hazardPkg;

	typedef logic [31:0] instrT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int RD_MSB    = 15;
	localparam int RD_LSB    = 11;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;

	// Primary opcodes
	localparam opcodeT OP_SPECIAL = 6'b000000;
	localparam opcodeT OP_REGIMM  = 6'b000001;
	localparam opcodeT OP_JAL     = 6'b000011;
	localparam opcodeT OP_BEQ     = 6'b000100;
	localparam opcodeT OP_BNE     = 6'b000101;
	localparam opcodeT OP_BLEZ    = 6'b000110;
	localparam opcodeT OP_BGTZ    = 6'b000111;
	localparam opcodeT OP_ADDI    = 6'b001000;
	localparam opcodeT OP_ADDIU   = 6'b001001;
	localparam opcodeT OP_SLTI    = 6'b001010;
	localparam opcodeT OP_SLTIU   = 6'b001011;
	localparam opcodeT OP_ANDI    = 6'b001100;
	localparam opcodeT OP_ORI     = 6'b001101;
	localparam opcodeT OP_XORI    = 6'b001110;
	localparam opcodeT OP_LUI     = 6'b001111;
	localparam opcodeT OP_LB      = 6'b100000;
	localparam opcodeT OP_LH      = 6'b100001;
	localparam opcodeT OP_LW      = 6'b100011;
	localparam opcodeT OP_LBU     = 6'b100100;
	localparam opcodeT OP_LHU     = 6'b100101;
	localparam opcodeT OP_SB      = 6'b101000;
	localparam opcodeT OP_SH      = 6'b101001;
	localparam opcodeT OP_SW      = 6'b101011;

	// SPECIAL function codes
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM codes in the rt field
	localparam regAddrT RI_BLTZ   = 5'b00000;
	localparam regAddrT RI_BGEZ   = 5'b00001;
	localparam regAddrT RI_BGEZAL = 5'b10001;

	localparam regAddrT LINK_REG = 5'd31;

	// Decodes as sll r0, r0, 0
	localparam instrT NOP_INSTR = 32'h0000_0000;

	//////////////////////////////////////////////////////////////////////
	// Bypass selects
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		FWD_D_RF     = 2'd0,
		FWD_D_E_LINK = 2'd1,
		FWD_D_M      = 2'd2,
		FWD_D_W      = 2'd3
	} fwdDecT;

	typedef enum logic [1:0] {
		FWD_E_RF = 2'd0,
		FWD_E_M  = 2'd1,
		FWD_E_W  = 2'd2
	} fwdExT;

endpackage

`default_nettype wire

// File: hw/instrClassify.sv
`default_nettype none

module instrClassify (
	input  hazardPkg::instrT   instr,
	output hazardPkg::regAddrT wrReg,
	output logic               isLoad,
	output logic               isStore,
	output logic               isLink,
	output logic               readsRs,
	output logic               readsRt,
	output logic               earlyRs,
	output logic               earlyRt
);
	import hazardPkg::*;

	opcodeT     op;
	logic [5:0] funct;
	regAddrT    rt;
	regAddrT    rd;

	assign op    = instr[OP_MSB:OP_LSB];
	assign funct = instr[FUNCT_MSB:FUNCT_LSB];
	assign rt    = instr[RT_MSB:RT_LSB];
	assign rd    = instr[RD_MSB:RD_LSB];

	//////////////////////////////////////////////////////////////////////
	// Destination and operand use
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		wrReg   = '0;
		isLoad  = 1'b0;
		isStore = 1'b0;
		isLink  = 1'b0;
		readsRs = 1'b0;
		readsRt = 1'b0;
		earlyRs = 1'b0;
		earlyRt = 1'b0;
		case (op)
			OP_SPECIAL: begin
				case (funct)
					// Shift amount comes from the word, rs unused
					FN_SLL, FN_SRL, FN_SRA: begin
						wrReg   = rd;
						readsRt = 1'b1;
					end
					FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
						wrReg   = rd;
						readsRs = 1'b1;
						readsRt = 1'b1;
					end
					FN_JR: begin
						readsRs = 1'b1;
						earlyRs = 1'b1;
					end
					FN_JALR: begin
						wrReg   = rd;
						isLink  = 1'b1;
						readsRs = 1'b1;
						earlyRs = 1'b1;
					end
					default: ;
				endcase
			end
			OP_REGIMM: begin
				if (rt == RI_BLTZ || rt == RI_BGEZ || rt == RI_BGEZAL) begin
					readsRs = 1'b1;
					earlyRs = 1'b1;
				end
				if (rt == RI_BGEZAL) begin
					wrReg  = LINK_REG;
					isLink = 1'b1;
				end
			end
			OP_JAL: begin
				wrReg  = LINK_REG;
				isLink = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
				earlyRs = 1'b1;
				earlyRt = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				readsRs = 1'b1;
				earlyRs = 1'b1;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
				wrReg   = rt;
				readsRs = 1'b1;
			end
			OP_LUI: wrReg = rt;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				wrReg   = rt;
				isLoad  = 1'b1;
				readsRs = 1'b1;
			end
			OP_SB, OP_SH, OP_SW: begin
				isStore = 1'b1;
				readsRs = 1'b1;
				readsRt = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/stageTrack.sv
`default_nettype none

module stageTrack (
	input  logic             clk,
	input  logic             rst,
	input  hazardPkg::instrT instrF,
	input  logic             stall,
	output hazardPkg::instrT instrD,
	output hazardPkg::instrT instrE,
	output hazardPkg::instrT instrM,
	output hazardPkg::instrT instrW
);
	import hazardPkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= NOP_INSTR;
			instrE <= NOP_INSTR;
			instrM <= NOP_INSTR;
			instrW <= NOP_INSTR;
		end else begin
			// Decode holds while stalled
			if (!stall) begin
				instrD <= instrF;
			end
			// Bubble into execute on a stall
			if (stall) begin
				instrE <= NOP_INSTR;
			end else begin
				instrE <= instrD;
			end
			instrM <= instrE;
			instrW <= instrM;
		end
	end

endmodule

`default_nettype wire

// File: hw/stallDetect.sv
`default_nettype none

module stallDetect (
	input  hazardPkg::regAddrT rsD,
	input  hazardPkg::regAddrT rtD,
	input  logic               readsRsD,
	input  logic               readsRtD,
	input  logic               earlyRsD,
	input  logic               earlyRtD,
	input  hazardPkg::regAddrT wrRegE,
	input  logic               isLoadE,
	input  logic               isLinkE,
	input  hazardPkg::regAddrT wrRegM,
	input  logic               isLoadM,
	output logic               stall
);
	import hazardPkg::*;

	logic rsLive;
	logic rtLive;
	logic loadUseRs;
	logic loadUseRt;
	logic earlyHitRs;
	logic earlyHitRt;

	// r0 never creates a dependency
	assign rsLive = rsD != '0;
	assign rtLive = rtD != '0;

	// Load in execute with data not back until writeback
	assign loadUseRs = isLoadE && readsRsD && rsLive && (rsD == wrRegE);
	assign loadUseRt = isLoadE && readsRtD && rtLive && (rtD == wrRegE);

	// Branch compare in decode needs the value now
	// Link results in execute are bypassed and never stall
	assign earlyHitRs = earlyRsD && rsLive &&
		(((rsD == wrRegE) && !isLinkE) || ((rsD == wrRegM) && isLoadM));
	assign earlyHitRt = earlyRtD && rtLive &&
		(((rtD == wrRegE) && !isLinkE) || ((rtD == wrRegM) && isLoadM));

	assign stall = loadUseRs || loadUseRt || earlyHitRs || earlyHitRt;

endmodule

`default_nettype wire

// File: hw/bypassSelect.sv
`default_nettype none

module bypassSelect (
	input  hazardPkg::regAddrT rsD,
	input  hazardPkg::regAddrT rtD,
	input  hazardPkg::regAddrT rsE,
	input  hazardPkg::regAddrT rtE,
	input  hazardPkg::regAddrT rtM,
	input  hazardPkg::regAddrT wrRegE,
	input  logic               isLinkE,
	input  hazardPkg::regAddrT wrRegM,
	input  logic               isLoadM,
	input  logic               isStoreM,
	input  hazardPkg::regAddrT wrRegW,
	input  logic               isLoadW,
	output hazardPkg::fwdDecT  fwdAD,
	output hazardPkg::fwdDecT  fwdBD,
	output hazardPkg::fwdExT   fwdAE,
	output hazardPkg::fwdExT   fwdBE,
	output logic               fwdM
);
	import hazardPkg::*;

	//////////////////////////////////////////////////////////////////////
	// Nearest producer first
	//////////////////////////////////////////////////////////////////////
	function automatic fwdDecT pickDec(
		input regAddrT src,
		input regAddrT wrE,
		input logic    linkE,
		input regAddrT wrM,
		input logic    loadM,
		input regAddrT wrW
	);
		fwdDecT sel;
		sel = FWD_D_RF;
		if (src != '0) begin
			if (linkE && (wrE == src)) begin
				sel = FWD_D_E_LINK;
			end else if (!loadM && (wrM == src)) begin
				sel = FWD_D_M;
			end else if (wrW == src) begin
				sel = FWD_D_W;
			end
		end
		return sel;
	endfunction

	// Load data in memory is not ready yet
	function automatic fwdExT pickEx(
		input regAddrT src,
		input regAddrT wrM,
		input logic    loadM,
		input regAddrT wrW
	);
		fwdExT sel;
		sel = FWD_E_RF;
		if (src != '0) begin
			if (!loadM && (wrM == src)) begin
				sel = FWD_E_M;
			end else if (wrW == src) begin
				sel = FWD_E_W;
			end
		end
		return sel;
	endfunction

	assign fwdAD = pickDec(rsD, wrRegE, isLinkE, wrRegM, isLoadM, wrRegW);
	assign fwdBD = pickDec(rtD, wrRegE, isLinkE, wrRegM, isLoadM, wrRegW);
	assign fwdAE = pickEx(rsE, wrRegM, isLoadM, wrRegW);
	assign fwdBE = pickEx(rtE, wrRegM, isLoadM, wrRegW);

	// Store data straight from the load in writeback
	assign fwdM = isStoreM && isLoadW && (rtM != '0) && (wrRegW == rtM);

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`default_nettype none

module hazardUnit (
	input  logic              clk,
	input  logic              rst,
	input  hazardPkg::instrT  instrF,
	output logic              stall,
	output hazardPkg::fwdDecT fwdAD,
	output hazardPkg::fwdDecT fwdBD,
	output hazardPkg::fwdExT  fwdAE,
	output hazardPkg::fwdExT  fwdBE,
	output logic              fwdM
);
	hazardPkg::instrT   instrD;
	hazardPkg::instrT   instrE;
	hazardPkg::instrT   instrM;
	hazardPkg::instrT   instrW;
	hazardPkg::regAddrT rsD;
	hazardPkg::regAddrT rtD;
	hazardPkg::regAddrT rsE;
	hazardPkg::regAddrT rtE;
	hazardPkg::regAddrT rtM;
	hazardPkg::regAddrT wrRegE;
	hazardPkg::regAddrT wrRegM;
	hazardPkg::regAddrT wrRegW;
	logic readsRsD;
	logic readsRtD;
	logic earlyRsD;
	logic earlyRtD;
	logic isLoadE;
	logic isLinkE;
	logic isLoadM;
	logic isStoreM;
	logic isLoadW;

	assign rsD = instrD[hazardPkg::RS_MSB:hazardPkg::RS_LSB];
	assign rtD = instrD[hazardPkg::RT_MSB:hazardPkg::RT_LSB];
	assign rsE = instrE[hazardPkg::RS_MSB:hazardPkg::RS_LSB];
	assign rtE = instrE[hazardPkg::RT_MSB:hazardPkg::RT_LSB];
	assign rtM = instrM[hazardPkg::RT_MSB:hazardPkg::RT_LSB];

	stageTrack stages (
		.clk    (clk),
		.rst    (rst),
		.instrF (instrF),
		.stall  (stall),
		.instrD (instrD),
		.instrE (instrE),
		.instrM (instrM),
		.instrW (instrW)
	);

	//////////////////////////////////////////////////////////////////////
	// One classifier per stage
	//////////////////////////////////////////////////////////////////////
	instrClassify clsD (
		.instr   (instrD),
		.wrReg   (),
		.isLoad  (),
		.isStore (),
		.isLink  (),
		.readsRs (readsRsD),
		.readsRt (readsRtD),
		.earlyRs (earlyRsD),
		.earlyRt (earlyRtD)
	);

	instrClassify clsE (
		.instr   (instrE),
		.wrReg   (wrRegE),
		.isLoad  (isLoadE),
		.isStore (),
		.isLink  (isLinkE),
		.readsRs (),
		.readsRt (),
		.earlyRs (),
		.earlyRt ()
	);

	instrClassify clsM (
		.instr   (instrM),
		.wrReg   (wrRegM),
		.isLoad  (isLoadM),
		.isStore (isStoreM),
		.isLink  (),
		.readsRs (),
		.readsRt (),
		.earlyRs (),
		.earlyRt ()
	);

	instrClassify clsW (
		.instr   (instrW),
		.wrReg   (wrRegW),
		.isLoad  (isLoadW),
		.isStore (),
		.isLink  (),
		.readsRs (),
		.readsRt (),
		.earlyRs (),
		.earlyRt ()
	);

	stallDetect stallCalc (
		.rsD      (rsD),
		.rtD      (rtD),
		.readsRsD (readsRsD),
		.readsRtD (readsRtD),
		.earlyRsD (earlyRsD),
		.earlyRtD (earlyRtD),
		.wrRegE   (wrRegE),
		.isLoadE  (isLoadE),
		.isLinkE  (isLinkE),
		.wrRegM   (wrRegM),
		.isLoadM  (isLoadM),
		.stall    (stall)
	);

	bypassSelect bypass (
		.rsD      (rsD),
		.rtD      (rtD),
		.rsE      (rsE),
		.rtE      (rtE),
		.rtM      (rtM),
		.wrRegE   (wrRegE),
		.isLinkE  (isLinkE),
		.wrRegM   (wrRegM),
		.isLoadM  (isLoadM),
		.isStoreM (isStoreM),
		.wrRegW   (wrRegW),
		.isLoadW  (isLoadW),
		.fwdAD    (fwdAD),
		.fwdBD    (fwdBD),
		.fwdAE    (fwdAE),
		.fwdBE    (fwdBE),
		.fwdM     (fwdM)
	);

endmodule

`default_nettype wire

// File: bench/hazardUnit_asserts.sv
`default_nettype none

module hazardUnitChecks (
	input logic              clk,
	input logic              rst,
	input hazardPkg::instrT  instrF,
	input logic              stall,
	input hazardPkg::fwdDecT fwdAD,
	input hazardPkg::fwdDecT fwdBD,
	input hazardPkg::fwdExT  fwdAE,
	input hazardPkg::fwdExT  fwdBE,
	input logic              fwdM
);
	timeunit 1ns;
	timeprecision 100ps;
	import hazardPkg::*;

	typedef struct packed {
		regAddrT wr;
		logic    ld;
		logic    st;
		logic    link;
		logic    useRs;
		logic    useRt;
		logic    earlyRs;
		logic    earlyRt;
	} useT;

	instrT  mirD;
	instrT  mirE;
	instrT  mirM;
	instrT  mirW;
	useT    uD;
	useT    uE;
	useT    uM;
	useT    uW;
	logic   expStall;
	fwdDecT expAD;
	fwdDecT expBD;
	fwdExT  expAE;
	fwdExT  expBE;
	logic   expM;

	function automatic useT classify(instrT i);
		useT        u;
		opcodeT     op;
		logic [5:0] fn;
		regAddrT    rt;
		logic       special;
		logic       shiftImm;
		logic       regAlu;
		logic       immAlu;
		logic       jalr;
		logic       twoReg;
		logic       oneReg;
		logic       bgezal;
		op = i[OP_MSB:OP_LSB];
		fn = i[FUNCT_MSB:FUNCT_LSB];
		rt = i[RT_MSB:RT_LSB];
		special = op == OP_SPECIAL;
		shiftImm = special && (fn inside {FN_SLL, FN_SRL, FN_SRA});
		regAlu = special && (fn inside {FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU,
			FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU});
		jalr = special && fn == FN_JALR;
		immAlu = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
		twoReg = op inside {OP_BEQ, OP_BNE};
		oneReg = (op inside {OP_BLEZ, OP_BGTZ}) ||
			(op == OP_REGIMM && (rt inside {RI_BLTZ, RI_BGEZ, RI_BGEZAL}));
		bgezal = op == OP_REGIMM && rt == RI_BGEZAL;
		u.ld = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		u.st = op inside {OP_SB, OP_SH, OP_SW};
		u.wr = '0;
		if (regAlu || shiftImm || jalr) begin
			u.wr = i[RD_MSB:RD_LSB];
		end else if (immAlu || u.ld || op == OP_LUI) begin
			u.wr = rt;
		end else if (op == OP_JAL || bgezal) begin
			u.wr = LINK_REG;
		end
		u.link = op == OP_JAL || jalr || bgezal;
		u.earlyRs = twoReg || oneReg || jalr || (special && fn == FN_JR);
		u.earlyRt = twoReg;
		u.useRs = u.earlyRs || regAlu || immAlu || u.ld || u.st;
		u.useRt = twoReg || regAlu || shiftImm || u.st;
		return u;
	endfunction

	function automatic logic needsStall(regAddrT src, logic used, logic early, useT e, useT m);
		if (src == '0) begin
			return 1'b0;
		end
		if (used && e.ld && e.wr == src) begin
			return 1'b1;
		end
		return early && ((e.wr == src && !e.link) || (m.ld && m.wr == src));
	endfunction

	function automatic fwdDecT decSource(regAddrT src, useT e, useT m, useT w);
		if (src == '0) begin
			return FWD_D_RF;
		end
		if (e.link && e.wr == src) begin
			return FWD_D_E_LINK;
		end
		if (!m.ld && m.wr == src) begin
			return FWD_D_M;
		end
		return (w.wr == src) ? FWD_D_W : FWD_D_RF;
	endfunction

	function automatic fwdExT exSource(regAddrT src, useT m, useT w);
		if (src == '0) begin
			return FWD_E_RF;
		end
		if (!m.ld && m.wr == src) begin
			return FWD_E_M;
		end
		return (w.wr == src) ? FWD_E_W : FWD_E_RF;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Mirror of the stage words, taken from the ports only
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			mirD <= NOP_INSTR;
			mirE <= NOP_INSTR;
			mirM <= NOP_INSTR;
			mirW <= NOP_INSTR;
		end else begin
			if (!stall) begin
				mirD <= instrF;
			end
			mirE <= stall ? NOP_INSTR : mirD;
			mirM <= mirE;
			mirW <= mirM;
		end
	end

	assign uD = classify(mirD);
	assign uE = classify(mirE);
	assign uM = classify(mirM);
	assign uW = classify(mirW);

	assign expStall = needsStall(mirD[RS_MSB:RS_LSB], uD.useRs, uD.earlyRs, uE, uM) ||
		needsStall(mirD[RT_MSB:RT_LSB], uD.useRt, uD.earlyRt, uE, uM);
	assign expAD = decSource(mirD[RS_MSB:RS_LSB], uE, uM, uW);
	assign expBD = decSource(mirD[RT_MSB:RT_LSB], uE, uM, uW);
	assign expAE = exSource(mirE[RS_MSB:RS_LSB], uM, uW);
	assign expBE = exSource(mirE[RT_MSB:RT_LSB], uM, uW);
	assign expM = uM.st && uW.ld && mirM[RT_MSB:RT_LSB] != '0 &&
		uW.wr == mirM[RT_MSB:RT_LSB];

	//////////////////////////////////////////////////////////////////////
	// Rule checks
	//////////////////////////////////////////////////////////////////////
	stallRule: assert property (@(posedge clk) disable iff (rst) stall == expStall)
		else begin
			hazardUnitTb.assertFails++;
			$error("FAIL stall %h expected %h", $sampled(stall), $sampled(expStall));
		end
	decARule: assert property (@(posedge clk) disable iff (rst) fwdAD == expAD)
		else begin
			hazardUnitTb.assertFails++;
			$error("FAIL fwdAD %h expected %h", $sampled(fwdAD), $sampled(expAD));
		end
	decBRule: assert property (@(posedge clk) disable iff (rst) fwdBD == expBD)
		else begin
			hazardUnitTb.assertFails++;
			$error("FAIL fwdBD %h expected %h", $sampled(fwdBD), $sampled(expBD));
		end
	exARule: assert property (@(posedge clk) disable iff (rst) fwdAE == expAE)
		else begin
			hazardUnitTb.assertFails++;
			$error("FAIL fwdAE %h expected %h", $sampled(fwdAE), $sampled(expAE));
		end
	exBRule: assert property (@(posedge clk) disable iff (rst) fwdBE == expBE)
		else begin
			hazardUnitTb.assertFails++;
			$error("FAIL fwdBE %h expected %h", $sampled(fwdBE), $sampled(expBE));
		end
	memRule: assert property (@(posedge clk) disable iff (rst) fwdM == expM)
		else begin
			hazardUnitTb.assertFails++;
			$error("FAIL fwdM %h expected %h", $sampled(fwdM), $sampled(expM));
		end

endmodule

`default_nettype wire

// File: bench/hazardUnitTb.sv
`default_nettype none

module hazardUnitTb;
	timeunit 1ns;
	timeprecision 100ps;
	import hazardPkg::*;

	localparam logic [31:0] SEED = 32'h9198;
	localparam int STALL_LIMIT = 8;
	localparam int RANDOM_COUNT = 2000;

	logic   clk;
	logic   rst;
	instrT  instrF;
	logic   stall;
	fwdDecT fwdAD;
	fwdDecT fwdBD;
	fwdExT  fwdAE;
	fwdExT  fwdBE;
	logic   fwdM;

	int assertFails = 0;
	int checkFails = 0;
	int timeouts = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int failMark;
	int held;

	hazardUnit hazardUnit_i (
		.clk    (clk),
		.rst    (rst),
		.instrF (instrF),
		.stall  (stall),
		.fwdAD  (fwdAD),
		.fwdBD  (fwdBD),
		.fwdAE  (fwdAE),
		.fwdBE  (fwdBE),
		.fwdM   (fwdM)
	);

	bind hazardUnit hazardUnitChecks checks (
		.clk    (clk),
		.rst    (rst),
		.instrF (instrF),
		.stall  (stall),
		.fwdAD  (fwdAD),
		.fwdBD  (fwdBD),
		.fwdAE  (fwdAE),
		.fwdBE  (fwdBE),
		.fwdM   (fwdM)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic instrT encR(logic [5:0] fn, regAddrT rs, regAddrT rt, regAddrT rd);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instrT encI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Small register pool so that hazards come often
	function automatic instrT randomInstr();
		regAddrT     a;
		regAddrT     b;
		regAddrT     c;
		logic [15:0] imm;
		instrT       w;
		a = 5'($urandom % 4);
		b = 5'($urandom % 4);
		c = 5'($urandom % 4);
		imm = 16'($urandom);
		case ($urandom % 22)
			0: w = encR(FN_ADDU, a, b, c);
			1: w = encR(FN_SUB, a, b, c);
			2: w = encR(FN_NOR, a, b, c);
			3: w = encR(FN_SLTU, a, b, c);
			4: w = encR(FN_SRA, 5'd0, b, c);
			5: w = encR(FN_SLLV, a, b, c);
			6: w = encI(OP_ADDIU, a, b, imm);
			7: w = encI(OP_SLTI, a, b, imm);
			8: w = encI(OP_LUI, 5'd0, b, imm);
			9: w = encI(OP_LW, a, b, imm);
			10: w = encI(OP_LBU, a, b, imm);
			11: w = encI(OP_LH, a, b, imm);
			12: w = encI(OP_SW, a, b, imm);
			13: w = encI(OP_SB, a, b, imm);
			14: w = encI(OP_BEQ, a, b, imm);
			15: w = encI(OP_BNE, a, b, imm);
			16: w = encI(OP_BGTZ, a, 5'd0, imm);
			17: w = encI(OP_REGIMM, a, RI_BGEZAL, imm);
			18: w = encI(OP_REGIMM, a, RI_BLTZ, imm);
			19: w = {OP_JAL, 26'($urandom)};
			20: w = encR(FN_JR, (a == 5'd3) ? LINK_REG : a, 5'd0, 5'd0);
			default: w = encR(FN_JALR, a, 5'd0, c);
		endcase
		return w;
	endfunction

	function automatic int failTotal();
		return assertFails + checkFails + timeouts;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driving and checking, always at the falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic countStall(output int n);
		n = 0;
		while (stall && n < STALL_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (stall) begin
			timeouts++;
			$display("Timeout: stall stayed high for %0d cycles", n);
		end
	endtask

	// Word waits on instrF until decode takes it
	task automatic issue(input instrT w);
		int n;
		instrF = w;
		countStall(n);
		@(negedge clk);
	endtask

	task automatic drain();
		repeat (4) issue(NOP_INSTR);
	endtask

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			checkFails++;
			$display("FAIL %0s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic beginTest();
		failMark = failTotal();
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (failTotal() != failMark) begin
			testsFailed++;
			$display("test %0s: failed", name);
		end else begin
			$display("test %0s: passed", name);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		instrF = NOP_INSTR;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		beginTest();
		checkVal("stall", 32'(stall), 32'd0);
		checkVal("fwdAD", 32'(fwdAD), 32'(FWD_D_RF));
		checkVal("fwdBD", 32'(fwdBD), 32'(FWD_D_RF));
		checkVal("fwdAE", 32'(fwdAE), 32'(FWD_E_RF));
		checkVal("fwdBE", 32'(fwdBE), 32'(FWD_E_RF));
		checkVal("fwdM", 32'(fwdM), 32'd0);
		endTest("reset");

		beginTest();
		issue(encI(OP_LW, 5'd2, 5'd1, 16'd0));
		issue(encR(FN_ADDU, 5'd1, 5'd3, 5'd2));
		countStall(held);
		checkVal("stall cycles", 32'(held), 32'd1);
		issue(NOP_INSTR);
		checkVal("fwdAE", 32'(fwdAE), 32'(FWD_E_W));
		drain();
		issue(encI(OP_LW, 5'd2, 5'd0, 16'd0));
		issue(encR(FN_ADDU, 5'd0, 5'd3, 5'd2));
		countStall(held);
		checkVal("stall cycles", 32'(held), 32'd0);
		endTest("load-use");

		beginTest();
		drain();
		issue(encR(FN_ADDU, 5'd2, 5'd3, 5'd1));
		issue(encI(OP_BEQ, 5'd1, 5'd2, 16'd4));
		countStall(held);
		checkVal("stall cycles", 32'(held), 32'd1);
		checkVal("fwdAD", 32'(fwdAD), 32'(FWD_D_M));
		drain();
		issue(encI(OP_LW, 5'd2, 5'd1, 16'd0));
		issue(encI(OP_BEQ, 5'd1, 5'd2, 16'd4));
		countStall(held);
		checkVal("stall cycles", 32'(held), 32'd2);
		checkVal("fwdAD", 32'(fwdAD), 32'(FWD_D_W));
		drain();
		issue({OP_JAL, 26'd0});
		issue(encR(FN_JR, LINK_REG, 5'd0, 5'd0));
		countStall(held);
		checkVal("stall cycles", 32'(held), 32'd0);
		checkVal("fwdAD", 32'(fwdAD), 32'(FWD_D_E_LINK));
		endTest("early operand");

		beginTest();
		drain();
		issue(encR(FN_ADDU, 5'd2, 5'd3, 5'd1));
		issue(encI(OP_ORI, 5'd2, 5'd1, 16'd5));
		issue(encR(FN_XOR, 5'd1, 5'd1, 5'd3));
		issue(NOP_INSTR);
		checkVal("fwdAE", 32'(fwdAE), 32'(FWD_E_M));
		checkVal("fwdBE", 32'(fwdBE), 32'(FWD_E_M));
		endTest("execute priority");

		beginTest();
		drain();
		issue(encI(OP_LW, 5'd2, 5'd1, 16'd0));
		issue(encI(OP_SW, 5'd2, 5'd1, 16'd4));
		countStall(held);
		checkVal("stall cycles", 32'(held), 32'd1);
		issue(NOP_INSTR);
		issue(NOP_INSTR);
		// Store in memory, the stall bubble in writeback
		checkVal("fwdM", 32'(fwdM), 32'd0);
		endTest("store data");

		beginTest();
		drain();
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			issue(randomInstr());
		end
		drain();
		endTest("random mix");

		$display("tests %0d, failed %0d, assertion errors %0d, check errors %0d, timeouts %0d",
			testsRun, testsFailed, assertFails, checkFails, timeouts);
		if (failTotal() == 0 && testsFailed == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hazardUnit.f
hw/hazardPkg.sv
hw/instrClassify.sv
hw/stageTrack.sv
hw/stallDetect.sv
hw/bypassSelect.sv
hw/hazardUnit.sv
bench/hazardUnit_asserts.sv
bench/hazardUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module hazardUnitTb \
	-f hazardUnit.f -Mdir build

out=$(./build/VhazardUnitTb +verilator+error+limit+10000 || true)
echo "$out"
grep -qx "TEST RESULT: PASS" <<< "$out"
